// ==== Makefile ====
# Verilator build and run for the branch prediction unit

VERILATOR ?= verilator
TOP       ?= bp_unit_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  := >>> FAIL
PASS_MSG  := >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sources.f ====
+incdir+verilog
verilog/bp_pkg.sv
verilog/bp_direction_table.sv
verilog/bp_target_buffer.sv
verilog/bp_predictor.sv
verilog/bp_update_fifo.sv
verilog/bp_csr_apb.sv
verilog/bp_unit.sv
test/bp_unit_chk.sv
test/bp_unit_tb.sv

// ==== test/bp_unit_chk.sv ====
// queue and resolve handshake assertions
// bound into every update queue instance
`timescale 1ns/1ps
`include "bp_config.svh"

module bp_unit_chk
    import bp_pkg::*;
(
    input logic                                   clk,
    input logic                                   rstn,
    input logic                                   in_valid,
    input logic                                   in_ready,
    input bp_resolve_t                            in_rec,
    input logic [$clog2(`BP_FIFO_DEPTH + 1)-1:0]  count
);

    localparam int CNT_W = $clog2(`BP_FIFO_DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(`BP_FIFO_DEPTH);

    // a push while full or a pop while empty moves count out of range
    a_count_in_range: assert property (@(posedge clk) disable iff (!rstn)
        count <= FULL)
        else $error("queue count out of range, push while full or pop while empty");

    // execute holds its record until it transfers
    a_hold_record: assert property (@(posedge clk) disable iff (!rstn)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_rec)))
        else $error("resolve record changed while waiting for ready");

    a_ready_after_reset: assert property (@(posedge clk)
        $rose(rstn) |-> in_ready)
        else $error("queue not ready after reset");

endmodule

bind bp_update_fifo bp_unit_chk u_chk (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_rec    (in_rec),
    .count     (count)
);

// ==== test/bp_unit_tb.sv ====
// directed testbench for the branch prediction unit
// table reference model, APB and resolve tasks, LFSR and watchdog
`timescale 1ns/1ps
`include "bp_config.svh"

module bp_unit_tb
    import bp_pkg::*;
();

    localparam int ENTRIES  = 1 << `BP_IDX_W;
    localparam int TAG_SH   = `BP_IDX_W + 3;
    localparam int CW       = 68;
    localparam int WAIT_MAX = 64;
    // rough cycle budget of each test
    localparam int T_RESET  = 40;
    localparam int T_UNCOND = 40;
    localparam int T_DIRECT = 60;
    localparam int T_BP     = 120;
    localparam int T_STATS  = 80;
    localparam int MARGIN   = 200;
    localparam int RUN_MAX  = T_RESET + T_UNCOND + T_DIRECT + T_BP + T_STATS + MARGIN;

    localparam logic [`BP_APB_AW-1:0] A_CTRL = `BP_APB_AW'(`BP_REG_CTRL);
    localparam logic [`BP_APB_AW-1:0] A_UPD  = `BP_APB_AW'(`BP_REG_UPD_CNT);
    localparam logic [`BP_APB_AW-1:0] A_MISS = `BP_APB_AW'(`BP_REG_MISS_CNT);
    localparam logic [`BP_APB_AW-1:0] A_BAD  = `BP_APB_AW'('hC);

    logic                  clk;
    logic                  rstn;
    logic [31:0]           fetch_pc;
    bp_pred_t              pred;
    logic                  res_valid;
    logic                  res_ready;
    bp_resolve_t           res;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [`BP_APB_AW-1:0] paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;

    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;
    logic [31:0] lfsr = 32'h76ae_7a2a;

    // reference model of the tables
    logic        m_valid  [ENTRIES];
    logic [31:0] m_tag    [ENTRIES];
    bp_btype_e   m_btype  [ENTRIES];
    logic [31:0] m_target [ENTRIES];
    int          m_ctr    [ENTRIES];
    logic        m_pred_en;

    bp_unit UUT (
        .clk       (clk),
        .rstn      (rstn),
        .fetch_pc  (fetch_pc),
        .pred      (pred),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res       (res),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int idx_of(input logic [31:0] pc);
        return int'(pc[`BP_IDX_W+2:3]);
    endfunction

    function automatic void model_reset();
        for (int i = 0; i < ENTRIES; i++) begin
            m_valid[i] = 1'b0;
            m_tag[i] = '0;
            m_btype[i] = BT_NONE;
            m_target[i] = '0;
            m_ctr[i] = 2;
        end
        m_pred_en = 1'b1;
    endfunction

    function automatic void model_update(input bp_resolve_t r);
        int   i;
        logic same;
        i = idx_of(r.pc);
        same = m_valid[i] && (m_tag[i] == (r.pc >> TAG_SH));
        if (r.btype == BT_NONE) begin
            if (same) begin
                m_valid[i] = 1'b0;
            end
        end else if (!same) begin
            m_valid[i] = 1'b1;
            m_tag[i] = r.pc >> TAG_SH;
            m_btype[i] = r.btype;
            m_target[i] = r.target;
            // only conditional records touch the counter
            if (r.btype == BT_DIRECT) begin
                m_ctr[i] = 2;
            end
        end else begin
            m_btype[i] = r.btype;
            if (r.taken) begin
                m_target[i] = r.target;
            end
            if (r.btype == BT_DIRECT && r.taken && m_ctr[i] < 3) begin
                m_ctr[i]++;
            end else if (r.btype == BT_DIRECT && !r.taken && m_ctr[i] > 0) begin
                m_ctr[i]--;
            end
        end
    endfunction

    function automatic bp_pred_t model_predict(input logic [31:0] pc);
        bp_pred_t p;
        int       i;
        logic     hit;
        logic     dir;
        i = idx_of(pc);
        hit = m_valid[i] && (m_tag[i] == (pc >> TAG_SH));
        dir = (m_btype[i] == BT_UNCOND) || (m_btype[i] == BT_INDIRECT) ||
              (m_btype[i] == BT_DIRECT && m_ctr[i] >= 2);
        p.taken = m_pred_en && hit && dir;
        p.btype = hit ? m_btype[i] : BT_NONE;
        p.next_pc = p.taken ? m_target[i] : (pc[2] ? pc + 32'd4 : pc + 32'd8);
        return p;
    endfunction

    function automatic bp_resolve_t make_rec(input logic [31:0] pc, input logic [31:0] target,
                                             input bp_btype_e bt, input logic taken,
                                             input logic miss);
        bp_resolve_t r;
        r.pc = pc;
        r.target = target;
        r.btype = bt;
        r.taken = taken;
        r.mispredict = miss;
        return r;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check(input logic [CW-1:0] got, input logic [CW-1:0] exp,
                         input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic apb_write(input logic [`BP_APB_AW-1:0] addr, input logic [31:0] data);
        psel = 1'b1;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        step();
        penable = 1'b1;
        step();
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input logic [`BP_APB_AW-1:0] addr, output logic [31:0] data,
                            output logic err);
        logic rdy;
        psel = 1'b1;
        pwrite = 1'b0;
        paddr = addr;
        step();
        penable = 1'b1;
        #1;
        data = prdata;
        err = pslverr;
        rdy = pready;
        step();
        psel = 1'b0;
        penable = 1'b0;
        // no wait states on any access
        check(CW'(rdy), CW'(1'b1), "pready in access phase");
    endtask

    task automatic send_resolve(input bp_resolve_t rec);
        int waited;
        waited = 0;
        res = rec;
        res_valid = 1'b1;
        while (!res_ready && waited < WAIT_MAX) begin
            step();
            waited++;
        end
        if (!res_ready) begin
            timeouts++;
            $display("res_ready stayed low, record for pc %h was not sent", rec.pc);
        end
        step();
        res_valid = 1'b0;
    endtask

    task automatic check_pred(input logic [31:0] pc);
        fetch_pc = pc;
        #1;
        check(CW'(pred), CW'(model_predict(pc)), $sformatf("prediction for pc %h", pc));
        step();
    endtask

    // old prediction holds until the pop edge, new one after it
    task automatic resolve_and_apply(input bp_resolve_t rec);
        send_resolve(rec);
        check_pred(rec.pc);
        model_update(rec);
        check_pred(rec.pc);
    endtask

    task automatic wait_updates(input int expected);
        logic [31:0] cnt;
        logic        err;
        int          polls;
        cnt = '0;
        polls = 0;
        while (cnt != 32'(expected) && polls < WAIT_MAX) begin
            apb_read(A_UPD, cnt, err);
            polls++;
        end
        if (cnt != 32'(expected)) begin
            timeouts++;
            $display("update queue did not drain, UPD_CNT stuck at %0d", cnt);
        end
    endtask

    task automatic test_reset_miss();
        logic [31:0] data;
        logic        err;
        check(CW'(res_ready), CW'(1'b1), "res_ready after reset");
        for (int k = 0; k < 6; k++) begin
            check_pred(rand_bits(30) << 2);
        end
        // second slot of a pair
        check_pred((rand_bits(29) << 3) | 32'h4);
        apb_read(A_CTRL, data, err);
        check(CW'(data), CW'(3), "CTRL after reset");
        check(CW'(err), CW'(1'b0), "pslverr on CTRL");
        apb_read(A_UPD, data, err);
        check(CW'(data), CW'(0), "UPD_CNT after reset");
        apb_read(A_MISS, data, err);
        check(CW'(data), CW'(0), "MISS_CNT after reset");
    endtask

    task automatic test_uncond_indirect();
        logic [31:0] pc;
        pc = rand_bits(29) << 3;
        resolve_and_apply(make_rec(pc, rand_bits(30) << 2, BT_UNCOND, 1'b1, 1'b0));
        check_pred(pc | 32'h4);
        // same index, other tag
        check_pred(pc ^ 32'h0010_0000);
        pc = rand_bits(29) << 3;
        resolve_and_apply(make_rec(pc, rand_bits(30) << 2, BT_INDIRECT, 1'b1, 1'b0));
        check_pred(pc ^ 32'h8000_0000);
    endtask

    task automatic test_counter_hysteresis();
        logic [31:0] pc;
        logic [31:0] tgt;
        logic [6:0]  seq;
        pc = rand_bits(29) << 3;
        tgt = rand_bits(30) << 2;
        // taken, not taken twice, taken three times, not taken
        seq = 7'b0111001;
        for (int k = 0; k < 7; k++) begin
            resolve_and_apply(make_rec(pc, tgt, BT_DIRECT, seq[k], 1'b0));
            if (k == 2) begin
                check(CW'(pred.taken), CW'(1'b0), "direct branch after two not-taken");
            end
        end
        resolve_and_apply(make_rec(pc ^ 32'h0400_0000, tgt, BT_NONE, 1'b0, 1'b0));
        check_pred(pc);
        resolve_and_apply(make_rec(pc, tgt, BT_NONE, 1'b0, 1'b0));
    endtask

    task automatic test_backpressure();
        bp_resolve_t recs [5];
        logic [31:0] pc_a;
        logic [31:0] pc_b;
        pc_a = rand_bits(29) << 3;
        pc_b = pc_a ^ 32'h0000_0008;
        recs[0] = make_rec(pc_a, rand_bits(30) << 2, BT_UNCOND, 1'b1, 1'b0);
        recs[1] = make_rec(pc_b, rand_bits(30) << 2, BT_DIRECT, 1'b1, 1'b0);
        recs[2] = make_rec(pc_b, rand_bits(30) << 2, BT_DIRECT, 1'b0, 1'b1);
        recs[3] = make_rec(pc_b, rand_bits(30) << 2, BT_DIRECT, 1'b0, 1'b1);
        recs[4] = make_rec(pc_a, rand_bits(30) << 2, BT_INDIRECT, 1'b1, 1'b0);
        apb_write(A_UPD, 32'h0);
        apb_write(A_CTRL, 32'h1);
        for (int k = 0; k < 4; k++) begin
            send_resolve(recs[k]);
        end
        fork
            send_resolve(recs[4]);
            begin
                repeat (3) begin
                    check(CW'(res_ready), CW'(1'b0), "res_ready with a full queue");
                    step();
                end
                check_pred(pc_a);
                check_pred(pc_b);
                apb_write(A_CTRL, 32'h3);
            end
        join
        wait_updates(5);
        for (int k = 0; k < 5; k++) begin
            model_update(recs[k]);
        end
        check_pred(pc_a);
        check_pred(pc_b);
    endtask

    task automatic test_stats_ctrl();
        bp_resolve_t rec;
        logic [31:0] pc;
        logic [31:0] data;
        logic        err;
        int          flagged;
        flagged = 0;
        pc = '0;
        apb_write(A_UPD, 32'h0);
        for (int k = 0; k < 6; k++) begin
            pc = rand_bits(29) << 3;
            rec = make_rec(pc, rand_bits(30) << 2, (k % 2 != 0) ? BT_DIRECT : BT_UNCOND,
                           1'b1, rand_bits(1) != 0);
            if (rec.mispredict) begin
                flagged++;
            end
            resolve_and_apply(rec);
        end
        apb_read(A_UPD, data, err);
        check(CW'(data), CW'(6), "UPD_CNT");
        apb_read(A_MISS, data, err);
        check(CW'(data), CW'(flagged), "MISS_CNT");
        apb_write(A_UPD, 32'hffff_ffff);
        apb_read(A_UPD, data, err);
        check(CW'(data), CW'(0), "UPD_CNT after clear");
        apb_read(A_MISS, data, err);
        check(CW'(data), CW'(0), "MISS_CNT after clear");
        // prediction off, the last entry falls through
        apb_write(A_CTRL, 32'h2);
        m_pred_en = 1'b0;
        check_pred(pc);
        apb_write(A_CTRL, 32'h3);
        m_pred_en = 1'b1;
        check_pred(pc);
        apb_read(A_BAD, data, err);
        check(CW'(err), CW'(1'b1), "pslverr on unmapped offset");
    endtask

    initial begin
        repeat (RUN_MAX) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not finish", RUN_MAX);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        rstn = 1'b0;
        fetch_pc = '0;
        res_valid = 1'b0;
        res = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        model_reset();
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        test_reset_miss();
        test_uncond_indirect();
        test_counter_hysteresis();
        test_backpressure();
        test_stats_ctrl();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog/bp_config.svh ====
// branch predictor build parameters
// table geometry, update queue depth and APB register map
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// index bits, 64 entries
`define BP_IDX_W 6

// tag is everything above the index
`define BP_TAG_W (32 - `BP_IDX_W - 3)

// resolve records buffered between execute and the tables
`define BP_FIFO_DEPTH 4

// APB address bits decoded by the register block
`define BP_APB_AW 8

// register byte offsets
`define BP_REG_CTRL 'h0
`define BP_REG_UPD_CNT 'h4
`define BP_REG_MISS_CNT 'h8

`endif

// ==== verilog/bp_csr_apb.sv ====
// APB register block for the branch predictor
// control bits, applied update and mispredict counters
`timescale 1ns/1ps
`include "bp_config.svh"

module bp_csr_apb
    import bp_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`BP_APB_AW-1:0] paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  pred_en,
    output logic                  upd_en,
    input  logic                  upd_fire,
    input  logic                  upd_miss
);

    bp_reg_e     reg_sel;
    logic        access;
    logic        mapped;
    logic        cnt_clr;
    logic [31:0] upd_cnt;
    logic [31:0] miss_cnt;

    assign reg_sel = bp_reg_e'(paddr);
    assign access  = psel && penable;
    assign mapped  = (reg_sel inside {REG_CTRL, REG_UPD_CNT, REG_MISS_CNT});
    // no wait states
    assign pready  = 1'b1;
    assign pslverr = access && !mapped;
    assign cnt_clr = access && pwrite && (reg_sel == REG_UPD_CNT);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pred_en <= 1'b1;
            upd_en  <= 1'b1;
        end else if (access && pwrite && reg_sel == REG_CTRL) begin
            pred_en <= pwdata[0];
            upd_en  <= pwdata[1];
        end
    end

    // clear wins over a same-cycle update
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            upd_cnt  <= '0;
            miss_cnt <= '0;
        end else if (cnt_clr) begin
            upd_cnt  <= '0;
            miss_cnt <= '0;
        end else if (upd_fire) begin
            upd_cnt <= upd_cnt + 32'd1;
            if (upd_miss) begin
                miss_cnt <= miss_cnt + 32'd1;
            end
        end
    end

    always_comb begin
        prdata = '0;
        case (reg_sel)
            REG_CTRL:     prdata = {30'd0, upd_en, pred_en};
            REG_UPD_CNT:  prdata = upd_cnt;
            REG_MISS_CNT: prdata = miss_cnt;
            default:      prdata = '0;
        endcase
    end

endmodule

// ==== verilog/bp_direction_table.sv ====
// direction table of 2-bit saturating counters
// combinational read port, one clocked write port
`timescale 1ns/1ps
`include "bp_config.svh"

module bp_direction_table
    import bp_pkg::*;
(
    input  logic                 clk,
    input  logic                 rstn,
    input  logic [`BP_IDX_W-1:0] rd_idx,
    output bp_ctr_e              rd_ctr,
    input  logic                 wr_en,
    input  logic [`BP_IDX_W-1:0] wr_idx,
    input  logic                 wr_init,
    input  logic                 wr_taken
);

    localparam int ENTRIES = 1 << `BP_IDX_W;

    bp_ctr_e ctr [ENTRIES];

    assign rd_ctr = ctr[rd_idx];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ctr[i] <= CTR_WEAK_T;
            end
        end else if (wr_en) begin
            if (wr_init) begin
                // fresh entry starts weakly taken
                ctr[wr_idx] <= CTR_WEAK_T;
            end else if (wr_taken) begin
                if (ctr[wr_idx] != CTR_STRONG_T) begin
                    ctr[wr_idx] <= bp_ctr_e'(ctr[wr_idx] + 2'd1);
                end
            end else begin
                if (ctr[wr_idx] != CTR_STRONG_NT) begin
                    ctr[wr_idx] <= bp_ctr_e'(ctr[wr_idx] - 2'd1);
                end
            end
        end
    end

endmodule

// ==== verilog/bp_pkg.sv ====
// branch predictor types
// branch kinds, counter states, register map and record structs
`include "bp_config.svh"

package bp_pkg;

    // branch type as seen by execute
    typedef enum logic [1:0] {
        BT_NONE     = 2'b00,
        BT_UNCOND   = 2'b01,
        // conditional, pc relative
        BT_DIRECT   = 2'b10,
        // register target, always taken
        BT_INDIRECT = 2'b11
    } bp_btype_e;

    // msb set means predict taken
    typedef enum logic [1:0] {
        CTR_STRONG_NT = 2'b00,
        CTR_WEAK_NT   = 2'b01,
        CTR_WEAK_T    = 2'b10,
        CTR_STRONG_T  = 2'b11
    } bp_ctr_e;

    typedef enum logic [`BP_APB_AW-1:0] {
        REG_CTRL     = `BP_APB_AW'(`BP_REG_CTRL),
        REG_UPD_CNT  = `BP_APB_AW'(`BP_REG_UPD_CNT),
        REG_MISS_CNT = `BP_APB_AW'(`BP_REG_MISS_CNT)
    } bp_reg_e;

    typedef struct packed {
        logic        taken;
        bp_btype_e   btype;
        logic [31:0] next_pc;
    } bp_pred_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] target;
        bp_btype_e   btype;
        logic        taken;
        logic        mispredict;
    } bp_resolve_t;

endpackage

// ==== verilog/bp_predictor.sv ====
// fetch predictor built from target buffer and direction counters
// forms next pc and applies queued update records
`timescale 1ns/1ps
`include "bp_config.svh"

module bp_predictor
    import bp_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic [31:0] fetch_pc,
    output bp_pred_t    pred,
    input  logic        pred_en,
    input  logic        upd_en,
    input  logic        upd_valid,
    input  bp_resolve_t upd,
    output logic        upd_pop
);

    logic        hit;
    bp_btype_e   hit_btype;
    logic [31:0] hit_target;
    logic        alloc;
    bp_ctr_e     rd_ctr;
    logic        dir_wr;
    logic        br_taken;
    logic [31:0] fall_pc;

    // one record per cycle while updates are enabled
    assign upd_pop = upd_valid && upd_en;
    // only conditional branches train the counters
    assign dir_wr  = upd_pop && (upd.btype == BT_DIRECT);

    bp_target_buffer u_btb (
        .clk        (clk),
        .rstn       (rstn),
        .fetch_pc   (fetch_pc),
        .hit        (hit),
        .hit_btype  (hit_btype),
        .hit_target (hit_target),
        .upd_en     (upd_pop),
        .upd        (upd),
        .alloc      (alloc)
    );

    bp_direction_table u_dir (
        .clk      (clk),
        .rstn     (rstn),
        .rd_idx   (fetch_pc[`BP_IDX_W+2:3]),
        .rd_ctr   (rd_ctr),
        .wr_en    (dir_wr),
        .wr_idx   (upd.pc[`BP_IDX_W+2:3]),
        .wr_init  (alloc),
        .wr_taken (upd.taken)
    );

    // second slot of a fetch pair falls through by 4
    assign fall_pc = fetch_pc[2] ? fetch_pc + 32'd4 : fetch_pc + 32'd8;

    always_comb begin
        br_taken = 1'b0;
        if (pred_en && hit) begin
            case (hit_btype)
                BT_UNCOND, BT_INDIRECT: br_taken = 1'b1;
                BT_DIRECT:              br_taken = rd_ctr[1];
                default:                br_taken = 1'b0;
            endcase
        end
    end

    assign pred.taken   = br_taken;
    assign pred.btype   = hit ? hit_btype : BT_NONE;
    assign pred.next_pc = br_taken ? hit_target : fall_pc;

endmodule

// ==== verilog/bp_target_buffer.sv ====
// direct-mapped branch target buffer
// fetch lookup, allocation, rewrite and invalidation
`timescale 1ns/1ps
`include "bp_config.svh"

module bp_target_buffer
    import bp_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic [31:0] fetch_pc,
    output logic        hit,
    output bp_btype_e   hit_btype,
    output logic [31:0] hit_target,
    input  logic        upd_en,
    input  bp_resolve_t upd,
    output logic        alloc
);

    localparam int ENTRIES = 1 << `BP_IDX_W;

    logic [ENTRIES-1:0]   valid;
    logic [`BP_TAG_W-1:0] tag_mem    [ENTRIES];
    bp_btype_e            btype_mem  [ENTRIES];
    logic [31:0]          target_mem [ENTRIES];

    logic [`BP_IDX_W-1:0] f_idx;
    logic [`BP_TAG_W-1:0] f_tag;
    logic [`BP_IDX_W-1:0] u_idx;
    logic [`BP_TAG_W-1:0] u_tag;
    logic                 u_hit;

    assign f_idx = fetch_pc[`BP_IDX_W+2:3];
    assign f_tag = fetch_pc[31:`BP_IDX_W+3];
    assign u_idx = upd.pc[`BP_IDX_W+2:3];
    assign u_tag = upd.pc[31:`BP_IDX_W+3];

    assign hit        = valid[f_idx] && (tag_mem[f_idx] == f_tag);
    assign hit_btype  = btype_mem[f_idx];
    assign hit_target = target_mem[f_idx];

    // update side tag compare
    assign u_hit = valid[u_idx] && (tag_mem[u_idx] == u_tag);
    assign alloc = (upd.btype != BT_NONE) && !u_hit;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
        end else if (upd_en) begin
            if (upd.btype == BT_NONE) begin
                if (u_hit) begin
                    valid[u_idx] <= 1'b0;
                end
            end else begin
                valid[u_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (upd_en && upd.btype != BT_NONE) begin
            tag_mem[u_idx]   <= u_tag;
            btype_mem[u_idx] <= upd.btype;
            // existing entry keeps its target on a not-taken record
            if (alloc || upd.taken) begin
                target_mem[u_idx] <= upd.target;
            end
        end
    end

endmodule

// ==== verilog/bp_unit.sv ====
// branch prediction unit top level
// update queue, predictor tables and APB register block
`timescale 1ns/1ps
`include "bp_config.svh"

module bp_unit
    import bp_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [31:0]           fetch_pc,
    output bp_pred_t              pred,
    input  logic                  res_valid,
    output logic                  res_ready,
    input  bp_resolve_t           res,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`BP_APB_AW-1:0] paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr
);

    logic        upd_valid;
    bp_resolve_t upd_rec;
    logic        upd_pop;
    logic        pred_en;
    logic        upd_en;

    // resolve records from execute
    bp_update_fifo u_fifo (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (res_valid),
        .in_ready  (res_ready),
        .in_rec    (res),
        .out_valid (upd_valid),
        .out_rec   (upd_rec),
        .pop       (upd_pop)
    );

    bp_predictor u_pred (
        .clk       (clk),
        .rstn      (rstn),
        .fetch_pc  (fetch_pc),
        .pred      (pred),
        .pred_en   (pred_en),
        .upd_en    (upd_en),
        .upd_valid (upd_valid),
        .upd       (upd_rec),
        .upd_pop   (upd_pop)
    );

    // statistics count on the pop edge
    bp_csr_apb u_csr (
        .clk      (clk),
        .rstn     (rstn),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .pred_en  (pred_en),
        .upd_en   (upd_en),
        .upd_fire (upd_pop),
        .upd_miss (upd_rec.mispredict)
    );

endmodule

// ==== verilog/bp_update_fifo.sv ====
// circular queue of resolve records
// same-cycle push and pop, ready while not full
`timescale 1ns/1ps
`include "bp_config.svh"

module bp_update_fifo
    import bp_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        in_valid,
    output logic        in_ready,
    input  bp_resolve_t in_rec,
    output logic        out_valid,
    output bp_resolve_t out_rec,
    input  logic        pop
);

    localparam int DEPTH = `BP_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    bp_resolve_t      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             empty;
    logic             push;
    logic             take;

    assign full      = (count == CNT_W'(DEPTH));
    assign empty     = (count == '0);
    assign in_ready  = !full;
    assign out_valid = !empty;
    assign out_rec   = mem[rd_ptr];
    assign push      = in_valid && !full;
    assign take      = pop && !empty;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (take) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // count holds on simultaneous push and pop
            if (push && !take) begin
                count <= count + 1'b1;
            end else if (take && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_rec;
        end
    end

endmodule
